/* filelist.f */
logic/vuad_pkg.sv
logic/vuad_stage_track.sv
logic/vuad_bypass_sel.sv
logic/vuad_wr_ctl.sv
logic/vuad_fill_alloc.sv
logic/vuad_ctl.sv
tb/vuad_ctl_asserts.sv
tb/vuad_ctl_tb.sv

/* logic/vuad_bypass_sel.sv */
/*
 VUAD read mux selects from the C1 index compares.
 sel_rd picks the array output when no younger stage matches.
*/
`timescale 1ns/1ps

module vuad_bypass_sel (
   input  logic                  rclk,
   input  logic                  rst,
   input  vuad_pkg::idx_cmp_t    idx_cmp,
   input  logic                  inst_int_c1,
   input  vuad_pkg::stage_vec_t  stages,
   input  vuad_pkg::wr_en_t      wr_en_c6,
   output logic                  sel_c2,
   output logic                  sel_c2_d1,
   output logic                  sel_c2orc3,
   output logic                  sel_c4,
   output logic                  sel_rd,
   output logic                  sel_ua_wr_data_byp,
   output logic                  sel_vd_wr_data_byp
);
   import vuad_pkg::*;

   logic sel_c3;
   logic sel_c5;     // Match on the instruction now writing
   logic sel_c5_d1;

   // Compare hit on a valid, non-interrupt stage
   function automatic logic stage_sel(input logic cmp, input stage_flags_t flags,
                                      input logic int_c1);
      stage_sel = cmp & flags.vld & ~(int_c1 | flags.intr);
   endfunction

   assign sel_c2 = stage_sel(idx_cmp.c2, stages.c2, inst_int_c1);
   assign sel_c3 = stage_sel(idx_cmp.c3, stages.c3, inst_int_c1);
   assign sel_c4 = stage_sel(idx_cmp.c4, stages.c4, inst_int_c1);
   assign sel_c5 = stage_sel(idx_cmp.c5, stages.c5, inst_int_c1);

   assign sel_c2orc3 = sel_c2 | sel_c3;
   assign sel_rd     = ~(sel_c2orc3 | sel_c4 | sel_c5);

   always_ff @(posedge rclk) begin
      if (rst) begin
         sel_c2_d1 <= 1'b0;
         sel_c5_d1 <= 1'b0;
      end else begin
         sel_c2_d1 <= sel_c2;
         sel_c5_d1 <= sel_c5;
      end
   end

   // Halves cross over here, same as the array wiring
   assign sel_ua_wr_data_byp = sel_c5_d1 & wr_en_c6.vd;
   assign sel_vd_wr_data_byp = sel_c5_d1 & wr_en_c6.ua;

endmodule

/* logic/vuad_ctl.sv */
/*
 VUAD control top. Fixed latency pipe, no stalls.
 Diagnostic access bits must arrive already registered at C3.
*/
`timescale 1ns/1ps

module vuad_ctl #(
   parameter int IDX_W = 10
) (
   input  logic                        rclk,
   input  logic                        rst,
   // C1
   input  vuad_pkg::idx_cmp_t          idx_cmp,
   input  logic                        inst_int_c1,
   input  logic                        inst_diag_c1,
   // C2
   input  logic                        inst_vld_c2,
   input  logic                        inst_fb_c2,
   input  vuad_pkg::way_num_u          inst_way_c2,
   input  logic                        pst_no_ctrue_c2,
   input  logic                        pst_with_ctrue_c2,
   input  logic                        cas1_inst_c2,
   input  logic                        cas2_inst_c2,
   input  logic                        inst_mb_c2,
   // C3
   input  logic                        l2vuad_vld_c3,
   input  logic                        st_inst_c3,
   input  logic                        acc_vd_c3,
   input  logic                        acc_ua_c3,
   input  logic                        bist_wr_en_c3,
   input  logic                        bist_wr_vd_c3,
   input  logic [IDX_W-1:0]            bist_idx_c3,
   input  logic [IDX_W-1:0]            idx_c3,
   // C4
   input  logic [vuad_pkg::PAR_W-1:0]  parity_c4,
   input  logic                        l2_bypass_mode_on,
   // Read mux selects
   output logic                        sel_c2,
   output logic                        sel_c2_d1,
   output logic                        sel_c2orc3,
   output logic                        sel_c4,
   output logic                        sel_rd,
   output logic                        sel_ua_wr_data_byp,
   output logic                        sel_vd_wr_data_byp,
   // Write control
   output vuad_pkg::wr_en_t            wr_en_c4,
   output logic                        bistordiag_wr_vd_c4,
   output logic                        bistordiag_wr_ua_c4,
   output logic                        sel_diag0_data_wr_c3,
   output logic                        sel_diag1_data_wr_c3,
   output logic [IDX_W-1:0]            vuad_idx_c4,
   // Fill and allocate
   output vuad_pkg::way_vec_t          fill_way_c3,
   output logic                        alloc_set_cond_c3,
   output logic                        alloc_rst_cond_c3,
   output logic                        vuad_error_c8
);
   import vuad_pkg::*;

   stage_vec_t stages;     // Per stage vld/int/diag
   wr_en_t     wr_en_c6;   // Feeds the write data bypass

   vuad_stage_track stage_track_i (
      .rclk          (rclk),
      .rst           (rst),
      .inst_int_c1   (inst_int_c1),
      .inst_diag_c1  (inst_diag_c1),
      .inst_vld_c2   (inst_vld_c2),
      .parity_c4     (parity_c4),
      .stages        (stages),
      .vuad_error_c8 (vuad_error_c8)
   );

   vuad_bypass_sel bypass_sel_i (
      .rclk               (rclk),
      .rst                (rst),
      .idx_cmp            (idx_cmp),
      .inst_int_c1        (inst_int_c1),
      .stages             (stages),
      .wr_en_c6           (wr_en_c6),
      .sel_c2             (sel_c2),
      .sel_c2_d1          (sel_c2_d1),
      .sel_c2orc3         (sel_c2orc3),
      .sel_c4             (sel_c4),
      .sel_rd             (sel_rd),
      .sel_ua_wr_data_byp (sel_ua_wr_data_byp),
      .sel_vd_wr_data_byp (sel_vd_wr_data_byp)
   );

   vuad_wr_ctl #(
      .IDX_W (IDX_W)
   ) wr_ctl_i (
      .rclk                 (rclk),
      .rst                  (rst),
      .stages               (stages),
      .l2_bypass_mode_on    (l2_bypass_mode_on),
      .l2vuad_vld_c3        (l2vuad_vld_c3),
      .st_inst_c3           (st_inst_c3),
      .acc_vd_c3            (acc_vd_c3),
      .acc_ua_c3            (acc_ua_c3),
      .bist_wr_en_c3        (bist_wr_en_c3),
      .bist_wr_vd_c3        (bist_wr_vd_c3),
      .bist_idx_c3          (bist_idx_c3),
      .idx_c3               (idx_c3),
      .sel_diag0_data_wr_c3 (sel_diag0_data_wr_c3),
      .sel_diag1_data_wr_c3 (sel_diag1_data_wr_c3),
      .bistordiag_wr_vd_c4  (bistordiag_wr_vd_c4),
      .bistordiag_wr_ua_c4  (bistordiag_wr_ua_c4),
      .wr_en_c4             (wr_en_c4),
      .wr_en_c6             (wr_en_c6),
      .vuad_idx_c4          (vuad_idx_c4)
   );

   vuad_fill_alloc fill_alloc_i (
      .rclk              (rclk),
      .rst               (rst),
      .inst_vld_c2       (inst_vld_c2),
      .inst_fb_c2        (inst_fb_c2),
      .inst_way_c2       (inst_way_c2),
      .pst_no_ctrue_c2   (pst_no_ctrue_c2),
      .pst_with_ctrue_c2 (pst_with_ctrue_c2),
      .cas1_inst_c2      (cas1_inst_c2),
      .cas2_inst_c2      (cas2_inst_c2),
      .inst_mb_c2        (inst_mb_c2),
      .fill_way_c3       (fill_way_c3),
      .alloc_set_cond_c3 (alloc_set_cond_c3),
      .alloc_rst_cond_c3 (alloc_rst_cond_c3)
   );

endmodule

/* logic/vuad_fill_alloc.sv */
/*
 Fill way decode and allocate bit conditions, registered into C3.
 Way numbers 12 to 15 alias onto ways 4 to 7.
*/
`timescale 1ns/1ps

module vuad_fill_alloc (
   input  logic                 rclk,
   input  logic                 rst,
   input  logic                 inst_vld_c2,
   input  logic                 inst_fb_c2,
   input  vuad_pkg::way_num_u   inst_way_c2,
   input  logic                 pst_no_ctrue_c2,
   input  logic                 pst_with_ctrue_c2,
   input  logic                 cas1_inst_c2,
   input  logic                 cas2_inst_c2,
   input  logic                 inst_mb_c2,
   output vuad_pkg::way_vec_t   fill_way_c3,
   output logic                 alloc_set_cond_c3,
   output logic                 alloc_rst_cond_c3
);
   import vuad_pkg::*;

   logic     fill_vld_c2;
   logic [3:0] dec_lo_c2;
   logic [2:0] grp_c2;         // Groups of four ways
   way_vec_t fill_way_c2;
   logic     alloc_set_cond_c2;
   logic     alloc_rst_cond_c2;

   assign fill_vld_c2 = inst_fb_c2 & inst_vld_c2;

   always_comb begin
      dec_lo_c2 = '0;
      dec_lo_c2[inst_way_c2.half.lo] = fill_vld_c2;
      grp_c2[0] = (inst_way_c2.half.hi == 2'd0);
      grp_c2[1] = inst_way_c2.raw[2];             // 01xx or 11xx
      grp_c2[2] = (inst_way_c2.half.hi == 2'd2);
      for (int g = 0; g < NUM_WAYS / 4; g++) begin
         fill_way_c2[g*4 +: 4] = grp_c2[g] ? dec_lo_c2 : 4'b0000;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Allocate bit set and reset
   ////////////////////////////////////////////////////////////////////////////

   assign alloc_set_cond_c2 = pst_no_ctrue_c2 | cas1_inst_c2;
   assign alloc_rst_cond_c2 = pst_with_ctrue_c2 |
                              (cas2_inst_c2 & inst_mb_c2) |
                              (inst_mb_c2 & ~alloc_set_cond_c2);   // MB replay

   always_ff @(posedge rclk) begin
      if (rst) begin
         fill_way_c3       <= '0;
         alloc_set_cond_c3 <= 1'b0;
         alloc_rst_cond_c3 <= 1'b0;
      end else begin
         fill_way_c3       <= fill_way_c2;
         alloc_set_cond_c3 <= alloc_set_cond_c2;
         alloc_rst_cond_c3 <= alloc_rst_cond_c2;
      end
   end

endmodule

/* logic/vuad_pkg.sv */
/*
 Shared widths and types for the VUAD control block of the L2 tag pipe.
 NUM_WAYS is fixed at 12 by the fill way decoder.
*/
package vuad_pkg;

   localparam int NUM_WAYS = 12;
   localparam int WAY_W    = 4;
   localparam int PAR_W    = 4;

   // One-hot way vector
   typedef logic [NUM_WAYS-1:0] way_vec_t;

   // Fill way number, raw or split into group and way-in-group
   typedef union packed {
      logic [WAY_W-1:0] raw;
      struct packed {
         logic [1:0] hi;   // Group select
         logic [1:0] lo;   // Way within group
      } half;
   } way_num_u;

   // C1 index compares against each stage
   typedef struct packed {
      logic c2;
      logic c3;
      logic c4;
      logic c5;
   } idx_cmp_t;

   typedef struct packed {
      logic vld;
      logic intr;
      logic diag;
   } stage_flags_t;

   typedef struct packed {
      stage_flags_t c2;
      stage_flags_t c3;
      stage_flags_t c4;
      stage_flags_t c5;
   } stage_vec_t;

   // Array write enables, ua is enable 0 and vd is enable 1
   typedef struct packed {
      logic vd;
      logic ua;
   } wr_en_t;

endpackage

/* logic/vuad_stage_track.sv */
/*
 Stage flags C2 to C5 and the VUAD parity error pipe.
 The C2 valid comes straight from the inst_vld_c2 input.
*/
`timescale 1ns/1ps

module vuad_stage_track (
   input  logic                        rclk,
   input  logic                        rst,
   input  logic                        inst_int_c1,
   input  logic                        inst_diag_c1,
   input  logic                        inst_vld_c2,
   input  logic [vuad_pkg::PAR_W-1:0]  parity_c4,
   output vuad_pkg::stage_vec_t        stages,
   output logic                        vuad_error_c8
);
   import vuad_pkg::*;

   logic         int_c2;
   logic         diag_c2;
   stage_flags_t flags_c2;
   stage_flags_t flags_c3;
   stage_flags_t flags_c4;
   stage_flags_t flags_c5;
   logic         vuad_error_c4;
   logic [3:0]   err_pipe;     // C5..C8, bit 3 is C8

   assign flags_c2.vld  = inst_vld_c2;
   assign flags_c2.intr = int_c2;
   assign flags_c2.diag = diag_c2;

   ////////////////////////////////////////////////////////////////////////////
   // Stage shift
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge rclk) begin
      if (rst) begin
         int_c2   <= 1'b0;
         diag_c2  <= 1'b0;
         flags_c3 <= '0;
         flags_c4 <= '0;
         flags_c5 <= '0;
      end else begin
         int_c2   <= inst_int_c1;
         diag_c2  <= inst_diag_c1;
         flags_c3 <= flags_c2;
         flags_c4 <= flags_c3;
         flags_c5 <= flags_c4;
      end
   end

   assign stages.c2 = flags_c2;
   assign stages.c3 = flags_c3;
   assign stages.c4 = flags_c4;
   assign stages.c5 = flags_c5;

   ////////////////////////////////////////////////////////////////////////////
   // Parity error, flagged at C4 and reported at C8
   ////////////////////////////////////////////////////////////////////////////

   // Diag and interrupt accesses never report
   assign vuad_error_c4 = flags_c4.vld & ~(flags_c4.diag | flags_c4.intr) &
                          (|parity_c4);

   always_ff @(posedge rclk) begin
      if (rst) begin
         err_pipe <= '0;
      end else begin
         err_pipe <= {err_pipe[2:0], vuad_error_c4};
      end
   end

   assign vuad_error_c8 = err_pipe[3];

endmodule

/* logic/vuad_wr_ctl.sv */
/*
 VUAD array write enables for normal, BIST and diagnostic writes.
 BIST owns the index whenever bist_wr_en_c3 is high.
*/
`timescale 1ns/1ps

module vuad_wr_ctl #(
   parameter int IDX_W = 10
) (
   input  logic                  rclk,
   input  logic                  rst,
   input  vuad_pkg::stage_vec_t  stages,
   input  logic                  l2_bypass_mode_on,
   input  logic                  l2vuad_vld_c3,
   input  logic                  st_inst_c3,
   input  logic                  acc_vd_c3,
   input  logic                  acc_ua_c3,
   input  logic                  bist_wr_en_c3,
   input  logic                  bist_wr_vd_c3,
   input  logic [IDX_W-1:0]      bist_idx_c3,
   input  logic [IDX_W-1:0]      idx_c3,
   output logic                  sel_diag0_data_wr_c3,
   output logic                  sel_diag1_data_wr_c3,
   output logic                  bistordiag_wr_vd_c4,
   output logic                  bistordiag_wr_ua_c4,
   output vuad_pkg::wr_en_t      wr_en_c4,
   output vuad_pkg::wr_en_t      wr_en_c6,
   output logic [IDX_W-1:0]      vuad_idx_c4
);
   import vuad_pkg::*;

   logic             l2_off_d1;
   logic             wr_disable_c3;
   logic             normal_wr_c3;
   logic             bistordiag_wr_vd_c3;
   logic             bistordiag_wr_ua_c3;
   wr_en_t           wr_en_c3;
   wr_en_t           wr_en_c5;
   logic [IDX_W-1:0] acc_idx_c3;

   ////////////////////////////////////////////////////////////////////////////
   // Write disable and select
   ////////////////////////////////////////////////////////////////////////////

   // Diag writes come back in through the diag select below
   assign wr_disable_c3 = stages.c3.intr | stages.c3.diag | l2_off_d1;
   assign normal_wr_c3  = stages.c3.vld & ~wr_disable_c3;

   assign sel_diag0_data_wr_c3 = l2vuad_vld_c3 & st_inst_c3 & acc_vd_c3;  // V, D half
   assign sel_diag1_data_wr_c3 = l2vuad_vld_c3 & st_inst_c3 & acc_ua_c3;  // U, A half

   assign bistordiag_wr_vd_c3 = sel_diag0_data_wr_c3 | (bist_wr_en_c3 & bist_wr_vd_c3);
   assign bistordiag_wr_ua_c3 = sel_diag1_data_wr_c3 | (bist_wr_en_c3 & ~bist_wr_vd_c3);

   assign wr_en_c3.vd = normal_wr_c3 | bistordiag_wr_vd_c3;
   assign wr_en_c3.ua = normal_wr_c3 | bistordiag_wr_ua_c3;

   assign acc_idx_c3 = bist_wr_en_c3 ? bist_idx_c3 : idx_c3;

   ////////////////////////////////////////////////////////////////////////////
   // Enable pipe C4 to C6
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge rclk) begin
      if (rst) begin
         l2_off_d1           <= 1'b0;
         bistordiag_wr_vd_c4 <= 1'b0;
         bistordiag_wr_ua_c4 <= 1'b0;
         wr_en_c4            <= '0;
         wr_en_c5            <= '0;
         wr_en_c6            <= '0;
      end else begin
         l2_off_d1           <= l2_bypass_mode_on;
         bistordiag_wr_vd_c4 <= bistordiag_wr_vd_c3;
         bistordiag_wr_ua_c4 <= bistordiag_wr_ua_c3;
         wr_en_c4            <= wr_en_c3;
         wr_en_c5            <= wr_en_c4;
         wr_en_c6            <= wr_en_c5;
      end
   end

   always_ff @(posedge rclk) begin
      vuad_idx_c4 <= acc_idx_c3;   // Array index
   end

endmodule

/* tb/vuad_ctl_asserts.sv */
/*
 Bound checks on the VUAD read selects and array write enables.
 Sampled on rclk; the release check is the only one active around reset.
*/
`timescale 1ns/1ps

module vuad_ctl_asserts (
   input logic             rclk,
   input logic             rst,
   input logic             sel_rd,
   input logic             sel_c2orc3,
   input vuad_pkg::wr_en_t wr_en_c4,
   input logic             bistordiag_wr_vd_c4,
   input logic             bistordiag_wr_ua_c4
);
   import vuad_pkg::*;

   localparam wr_en_t NO_WR = '0;

   int fail_count = 0;   // Failed assertion count

   // Array read and a C2/C3 bypass never both
   rd_vs_bypass: assert property (@(posedge rclk) disable iff (rst)
                                  !(sel_rd && sel_c2orc3))
      else begin
         fail_count++;
         $error("sel_rd high together with sel_c2orc3");
      end

   // First edge out of reset loads the enables from live C3 inputs
   quiet_after_rst: assert property (@(posedge rclk) $fell(rst) |=> wr_en_c4 == NO_WR)
      else begin
         fail_count++;
         $error("write enable high in the first cycle after reset");
      end

   vd_half: assert property (@(posedge rclk) disable iff (rst)
                             bistordiag_wr_vd_c4 |-> wr_en_c4.vd)
      else begin
         fail_count++;
         $error("bistordiag_wr_vd_c4 without the vd write enable");
      end

   ua_half: assert property (@(posedge rclk) disable iff (rst)
                             bistordiag_wr_ua_c4 |-> wr_en_c4.ua)
      else begin
         fail_count++;
         $error("bistordiag_wr_ua_c4 without the ua write enable");
      end

endmodule

bind vuad_ctl vuad_ctl_asserts vuad_ctl_asserts_i (
   .rclk                (rclk),
   .rst                 (rst),
   .sel_rd              (sel_rd),
   .sel_c2orc3          (sel_c2orc3),
   .wr_en_c4            (wr_en_c4),
   .bistordiag_wr_vd_c4 (bistordiag_wr_vd_c4),
   .bistordiag_wr_ua_c4 (bistordiag_wr_ua_c4)
);

/* tb/vuad_ctl_tb.sv */
/*
 Table driven testbench for the VUAD control top.
 Inputs change on the falling edge, outputs are sampled 1 ns later.
 Each row is followed by an idle flush so no two rows overlap in the pipe.
*/
`timescale 1ns/1ps

module vuad_ctl_tb;
   import vuad_pkg::*;

   localparam int IDX_W = 10;
   localparam int FLUSH = 8;              // Drains C2 through C8
   localparam int LIMIT_NS = 200_000;

   localparam logic [2:0] K_FILL  = 3'd0;
   localparam logic [2:0] K_ALLOC = 3'd1;
   localparam logic [2:0] K_WRITE = 3'd2;
   localparam logic [2:0] K_BIST  = 3'd3;
   localparam logic [2:0] K_DIAG  = 3'd4;
   localparam logic [2:0] K_BYP   = 3'd5;
   localparam logic [2:0] K_PAR   = 3'd6;

   typedef struct packed {
      logic [2:0]       kind;
      logic [7:0]       arg;       // Packed stimulus bits, meaning depends on kind
      logic [IDX_W-1:0] idx_bist;
      logic [IDX_W-1:0] idx_pipe;
      logic [15:0]      exp;
      logic [3:0]       offset;    // Cycles from the reference input to the check
   } row_t;

   logic             rclk;
   logic             rst;
   idx_cmp_t         idx_cmp;
   logic             inst_int_c1;
   logic             inst_diag_c1;
   logic             inst_vld_c2;
   logic             inst_fb_c2;
   way_num_u         inst_way_c2;
   logic             pst_no_ctrue_c2;
   logic             pst_with_ctrue_c2;
   logic             cas1_inst_c2;
   logic             cas2_inst_c2;
   logic             inst_mb_c2;
   logic             l2vuad_vld_c3;
   logic             st_inst_c3;
   logic             acc_vd_c3;
   logic             acc_ua_c3;
   logic             bist_wr_en_c3;
   logic             bist_wr_vd_c3;
   logic [IDX_W-1:0] bist_idx_c3;
   logic [IDX_W-1:0] idx_c3;
   logic [PAR_W-1:0] parity_c4;
   logic             l2_bypass_mode_on;

   logic             sel_c2;
   logic             sel_c2_d1;
   logic             sel_c2orc3;
   logic             sel_c4;
   logic             sel_rd;
   logic             sel_ua_wr_data_byp;
   logic             sel_vd_wr_data_byp;
   wr_en_t           wr_en_c4;
   logic             bistordiag_wr_vd_c4;
   logic             bistordiag_wr_ua_c4;
   logic             sel_diag0_data_wr_c3;
   logic             sel_diag1_data_wr_c3;
   logic [IDX_W-1:0] vuad_idx_c4;
   way_vec_t         fill_way_c3;
   logic             alloc_set_cond_c3;
   logic             alloc_rst_cond_c3;
   logic             vuad_error_c8;

   row_t table_q[$];
   int   checks;
   int   errors;

   vuad_ctl #(
      .IDX_W (IDX_W)
   ) vuad_ctl_i (
      .rclk                 (rclk),
      .rst                  (rst),
      .idx_cmp              (idx_cmp),
      .inst_int_c1          (inst_int_c1),
      .inst_diag_c1         (inst_diag_c1),
      .inst_vld_c2          (inst_vld_c2),
      .inst_fb_c2           (inst_fb_c2),
      .inst_way_c2          (inst_way_c2),
      .pst_no_ctrue_c2      (pst_no_ctrue_c2),
      .pst_with_ctrue_c2    (pst_with_ctrue_c2),
      .cas1_inst_c2         (cas1_inst_c2),
      .cas2_inst_c2         (cas2_inst_c2),
      .inst_mb_c2           (inst_mb_c2),
      .l2vuad_vld_c3        (l2vuad_vld_c3),
      .st_inst_c3           (st_inst_c3),
      .acc_vd_c3            (acc_vd_c3),
      .acc_ua_c3            (acc_ua_c3),
      .bist_wr_en_c3        (bist_wr_en_c3),
      .bist_wr_vd_c3        (bist_wr_vd_c3),
      .bist_idx_c3          (bist_idx_c3),
      .idx_c3               (idx_c3),
      .parity_c4            (parity_c4),
      .l2_bypass_mode_on    (l2_bypass_mode_on),
      .sel_c2               (sel_c2),
      .sel_c2_d1            (sel_c2_d1),
      .sel_c2orc3           (sel_c2orc3),
      .sel_c4               (sel_c4),
      .sel_rd               (sel_rd),
      .sel_ua_wr_data_byp   (sel_ua_wr_data_byp),
      .sel_vd_wr_data_byp   (sel_vd_wr_data_byp),
      .wr_en_c4             (wr_en_c4),
      .bistordiag_wr_vd_c4  (bistordiag_wr_vd_c4),
      .bistordiag_wr_ua_c4  (bistordiag_wr_ua_c4),
      .sel_diag0_data_wr_c3 (sel_diag0_data_wr_c3),
      .sel_diag1_data_wr_c3 (sel_diag1_data_wr_c3),
      .vuad_idx_c4          (vuad_idx_c4),
      .fill_way_c3          (fill_way_c3),
      .alloc_set_cond_c3    (alloc_set_cond_c3),
      .alloc_rst_cond_c3    (alloc_rst_cond_c3),
      .vuad_error_c8        (vuad_error_c8)
   );

   always #4 rclk = ~rclk;   // 8 ns period

   ////////////////////////////////////////////////////////////////////////////
   // Reference rules
   ////////////////////////////////////////////////////////////////////////////

   // Way groups of four; hi 3 folds onto group 1
   function automatic logic [15:0] fill_onehot(input logic [3:0] way, input logic fb);
      int grp;
      grp = (way[3:2] == 2'd0) ? 0 : ((way[3:2] == 2'd2) ? 2 : 1);
      fill_onehot = fb ? (16'h0001 << (grp * 4 + int'(way[1:0]))) : 16'h0000;
   endfunction

   // a is {pst_no, pst_with, cas1, cas2, mb}
   function automatic logic [15:0] alloc_conds(input logic [4:0] a);
      logic set_c;
      logic rst_c;
      set_c = a[4] | a[2];
      rst_c = a[3] | (a[1] & a[0]) | (a[0] & ~set_c);
      alloc_conds = {14'b0, set_c, rst_c};
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Drive and check helpers
   ////////////////////////////////////////////////////////////////////////////

   // L2 off is a level and stays out of here
   task automatic drive_idle();
      idx_cmp           = '0;
      inst_int_c1       = 1'b0;
      inst_diag_c1      = 1'b0;
      inst_vld_c2       = 1'b0;
      inst_fb_c2        = 1'b0;
      inst_way_c2       = '0;
      pst_no_ctrue_c2   = 1'b0;
      pst_with_ctrue_c2 = 1'b0;
      cas1_inst_c2      = 1'b0;
      cas2_inst_c2      = 1'b0;
      inst_mb_c2        = 1'b0;
      l2vuad_vld_c3     = 1'b0;
      st_inst_c3        = 1'b0;
      acc_vd_c3         = 1'b0;
      acc_ua_c3         = 1'b0;
      bist_wr_en_c3     = 1'b0;
      bist_wr_vd_c3     = 1'b0;
      bist_idx_c3       = '0;
      idx_c3            = '0;
      parity_c4         = '0;
   endtask

   // Bounded by n, one falling edge per pass
   task automatic idle_cycles(input int n);
      for (int i = 0; i < n; i++) begin
         @(negedge rclk);
         drive_idle();
      end
   endtask

   task automatic check(input string what, input logic [15:0] got, input logic [15:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic build_table();
      row_t r;
      for (int i = 0; i < 32; i++) begin
         r = '0;
         r.kind   = K_FILL;
         r.arg    = i[7:0];                  // {fb, way}
         r.exp    = fill_onehot(i[3:0], i[4]);
         r.offset = 4'd1;
         table_q.push_back(r);
         r.kind   = K_ALLOC;
         r.exp    = alloc_conds(i[4:0]);
         table_q.push_back(r);
      end
      for (int i = 0; i < 8; i++) begin
         r = '0;
         r.kind     = K_WRITE;
         r.arg      = i[7:0];                // {intr, diag, l2off}
         r.idx_pipe = IDX_W'($urandom);
         r.exp      = (i == 0) ? 16'b1100 : 16'b0000;
         r.offset   = 4'd2;
         table_q.push_back(r);
         r.kind     = K_BYP;                 // {intr, stage}
         r.exp      = {12'b0, (i[1:0] == 0) & ~i[2], (i[1:0] <= 1) & ~i[2],
                       (i[1:0] == 2) & ~i[2], i[2]};
         r.offset   = 4'(i[1:0]);
         table_q.push_back(r);
      end
      for (int i = 0; i < 4; i++) begin
         r = '0;
         r.kind     = K_DIAG;                // {acc_vd, acc_ua}
         r.arg      = i[7:0];
         r.exp      = {14'b0, i[1:0]};
         table_q.push_back(r);
         r.kind     = K_BIST;
         r.arg      = {7'b0, i[0]};
         r.idx_bist = IDX_W'($urandom);
         r.idx_pipe = ~r.idx_bist;
         r.exp      = {12'b0, i[0], ~i[0], i[0], ~i[0]};
         r.offset   = 4'd1;
         table_q.push_back(r);
      end
      for (int i = 0; i < 18; i++) begin
         r = '0;
         r.kind   = K_PAR;                   // {diag, parity}
         r.arg    = (i < 16) ? i[7:0] : {3'b001, 4'($urandom_range(15, 1))};
         r.exp    = {15'b0, ~r.arg[4] & (r.arg[3:0] != 4'h0)};
         r.offset = 4'd4;
         table_q.push_back(r);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // One table row
   ////////////////////////////////////////////////////////////////////////////

   task automatic run_row(input row_t r);
      logic [31:0] rnd;
      rnd = $urandom;
      idle_cycles(1);
      case (r.kind)
         K_FILL: begin
            inst_vld_c2       = 1'b1;
            inst_fb_c2        = r.arg[4];
            inst_way_c2.raw   = r.arg[3:0];
            pst_no_ctrue_c2   = rnd[0];      // Allocate inputs do not matter here
            pst_with_ctrue_c2 = rnd[1];
            cas1_inst_c2      = rnd[2];
            cas2_inst_c2      = rnd[3];
            inst_mb_c2        = rnd[4];
            idle_cycles(r.offset);
            #1;
            check("fill_way_c3", fill_way_c3, r.exp);
         end
         K_ALLOC: begin
            {pst_no_ctrue_c2, pst_with_ctrue_c2, cas1_inst_c2, cas2_inst_c2,
             inst_mb_c2} = r.arg[4:0];
            inst_fb_c2      = rnd[0];
            inst_way_c2.raw = rnd[7:4];
            idle_cycles(r.offset);
            #1;
            check("alloc set/rst", {alloc_set_cond_c3, alloc_rst_cond_c3}, r.exp);
         end
         K_WRITE: begin
            l2_bypass_mode_on = r.arg[0];
            inst_int_c1       = r.arg[2];
            inst_diag_c1      = r.arg[1];
            idle_cycles(1);
            inst_vld_c2 = 1'b1;
            idle_cycles(1);
            idx_c3 = r.idx_pipe;
            idle_cycles(r.offset - 1);
            #1;
            check("normal write enables", {wr_en_c4.vd, wr_en_c4.ua, bistordiag_wr_vd_c4,
                  bistordiag_wr_ua_c4}, r.exp);
            check("pipe index", 16'(vuad_idx_c4), 16'(r.idx_pipe));
         end
         K_BIST: begin
            bist_wr_en_c3 = 1'b1;
            bist_wr_vd_c3 = r.arg[0];
            bist_idx_c3   = r.idx_bist;
            idx_c3        = r.idx_pipe;
            idle_cycles(r.offset);
            #1;
            check("bist write enables", {wr_en_c4.vd, wr_en_c4.ua, bistordiag_wr_vd_c4,
                  bistordiag_wr_ua_c4}, r.exp);
            check("bist index", 16'(vuad_idx_c4), 16'(r.idx_bist));
         end
         K_DIAG: begin
            l2vuad_vld_c3 = 1'b1;
            st_inst_c3    = 1'b1;
            acc_vd_c3     = r.arg[1];
            acc_ua_c3     = r.arg[0];
            #1;
            check("diag data selects", {sel_diag0_data_wr_c3, sel_diag1_data_wr_c3}, r.exp);
         end
         K_BYP: begin
            inst_vld_c2 = 1'b1;
            idle_cycles(r.offset);
            // Only the target stage is valid, other compare bits are free
            idx_cmp     = rnd[3:0] | (4'b1000 >> r.arg[1:0]);
            inst_int_c1 = r.arg[2];
            #1;
            check("read selects", {sel_c2, sel_c2orc3, sel_c4, sel_rd}, r.exp);
            if (r.arg[1:0] == 2'd0) begin
               idle_cycles(1);
               #1;
               check("sel_c2_d1", sel_c2_d1, r.exp[3]);
            end
            // C5 match on a normal write, both halves reach C6 next cycle
            if (r.arg[1:0] == 2'd3) begin
               idle_cycles(1);
               #1;
               check("write data bypass", {sel_ua_wr_data_byp, sel_vd_wr_data_byp},
                     {2{~r.arg[2]}});
            end
         end
         default: begin
            inst_diag_c1 = r.arg[4];
            idle_cycles(1);
            inst_vld_c2 = 1'b1;
            idle_cycles(2);
            parity_c4 = r.arg[3:0];
            for (int k = 0; k <= 6; k++) begin
               #1;
               check($sformatf("vuad_error_c8 at +%0d", k), vuad_error_c8,
                     (k == r.offset) ? r.exp : 16'h0000);
               idle_cycles(1);
            end
         end
      endcase
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      checks            = 0;
      errors            = 0;
      rclk              = 1'b0;
      rst               = 1'b1;
      l2_bypass_mode_on = 1'b0;
      drive_idle();
      void'($urandom(8280));
      build_table();
      idle_cycles(10);
      rst = 1'b0;
      idle_cycles(1);
      #1;
      check("read selects after reset", {sel_c2, sel_c2_d1, sel_c2orc3, sel_c4, sel_rd},
            16'h0001);
      check("write outputs after reset", {sel_ua_wr_data_byp, sel_vd_wr_data_byp, wr_en_c4,
            bistordiag_wr_vd_c4, bistordiag_wr_ua_c4, sel_diag0_data_wr_c3,
            sel_diag1_data_wr_c3}, 16'h0000);
      check("fill, alloc, error after reset", {fill_way_c3, alloc_set_cond_c3,
            alloc_rst_cond_c3, vuad_error_c8}, 16'h0000);
      foreach (table_q[n]) begin
         run_row(table_q[n]);
         @(negedge rclk);
         l2_bypass_mode_on = 1'b0;
         drive_idle();
         idle_cycles(FLUSH);
      end
      $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
               vuad_ctl_i.vuad_ctl_asserts_i.fail_count);
      if (errors == 0 && vuad_ctl_i.vuad_ctl_asserts_i.fail_count == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   // Watchdog for the whole run
   initial begin
      #(LIMIT_NS);
      $display("Timeout: the run did not finish within %0d ns", LIMIT_NS);
      $display("Test failed");
      $finish;
   end

endmodule
